// File: bench/exu_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result timing and write enable assertions bound to exu_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module exu_asserts (
    input wire                   clk,
    input wire                   i_arst_n,
    input logic                  i_op_valid,
    input logic                  i_wb_valid,
    input exu_pkg::exu_result_t  i_wb,
    input exu_pkg::exu_mem_op_t  i_exe_mem_op,
    input exu_pkg::dmem_req_t    i_dmem_req
);
    import exu_pkg::*;

    // failed assertions so far
    int   fail_cnt = 0;
    logic misaligned;

    // alignment of the op now in the memory stage
    assign misaligned = ((i_exe_mem_op.size == HALF) && i_exe_mem_op.result[0]) ||
                        ((i_exe_mem_op.size == WORD) && (i_exe_mem_op.result[1:0] != 2'b00));

    a_wb_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_wb_valid == $past(i_op_valid, EXU_LATENCY))
        else begin
            fail_cnt++;
            $error("result strobe not %0d cycles after accept", EXU_LATENCY);
        end

    // a register write needs an op that entered the memory stage clean and aligned
    a_wr_en_cause: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_wb_valid && i_wb.wr_en) |->
            (($past(i_exe_mem_op.cause) == NONE) &&
             !$past(i_exe_mem_op.mem_req && misaligned)))
        else begin
            fail_cnt++;
            $error("register write for an op with an overflow or misaligned access");
        end

    a_wb_known: assert property (@(posedge clk) disable iff (!i_arst_n)
        !$isunknown(i_wb_valid))
        else begin
            fail_cnt++;
            $error("result strobe unknown");
        end

    a_no_misaligned_write: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_dmem_req.we |-> !misaligned)
        else begin
            fail_cnt++;
            $error("memory write for a misaligned access");
        end

endmodule

bind exu_top exu_asserts u_asserts (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_op_valid   (i_op_valid),
    .i_wb_valid   (o_wb_valid),
    .i_wb         (o_wb),
    .i_exe_mem_op (exe_mem_op),
    .i_dmem_req   (dmem_req)
);

`default_nettype wire

// File: bench/exu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for exu_top: reference model with shadow
// memory, result compare, timeout and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module exu_tb;
    import exu_pkg::*;

    localparam int RST_CYCLES  = 10;
    localparam int N_TESTS     = 6;
    // ops issued over all tests, 200 of them random, rounded up
    localparam int OP_BUDGET   = 300;
    // each test ends with one idle cycle and a drain of the pipe
    localparam int TIMEOUT_CYC = RST_CYCLES + OP_BUDGET + N_TESTS * (EXU_LATENCY + 3) + 100;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        op_valid;
    exu_op_t     op;
    logic        wb_valid;
    exu_result_t wb;

    // expected results in issue order
    exu_result_t       exp_q[$];
    // model copy of the data memory
    logic [DATA_W-1:0] shadow [DMEM_WORDS];
    int                cycles = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests  = 0;
    int                test_err0 = 0;

    always #2 clk = ~clk;

    exu_top i_dut (
        .clk        (clk),
        .i_arst_n   (arst_n),
        .i_op_valid (op_valid),
        .i_op       (op),
        .o_wb_valid (wb_valid),
        .o_wb       (wb)
    );

    // behavioral model of one operation, updates the shadow memory for stores
    function automatic exu_result_t model_op(input exu_op_t o);
        logic [DATA_W-1:0] opa;
        logic [DATA_W-1:0] opb;
        logic [DATA_W-1:0] res;
        logic [DATA_W-1:0] word;
        logic [DATA_W:0]   wide;
        logic              ovf;
        logic [5:0]        widx;
        int                hi;
        exu_result_t       r;
        opa = o.shift_imm ? {27'b0, o.imm[10:6]} : o.a;
        opb = o.alu_imm ? o.imm : o.b;
        // sign-extended 33-bit sum, overflow when the top two bits disagree
        wide = '0;
        if (o.func == ADD) begin
            wide = {opa[31], opa} + {opb[31], opb};
        end else if (o.func == SUB) begin
            wide = {opa[31], opa} - {opb[31], opb};
        end
        ovf = wide[32] != wide[31];
        case (o.func)
            ADD, SUB: res = wide[31:0];
            AND:      res = opa & opb;
            OR:       res = opa | opb;
            XOR:      res = opa ^ opb;
            NOR:      res = ~(opa | opb);
            SLL:      res = opb << opa[4:0];
            SRL:      res = opb >> opa[4:0];
            SRA:      res = $signed(opb) >>> opa[4:0];
            LUI:      res = {o.imm[15:0], 16'h0000};
            default:  res = '0;
        endcase
        // signs differ: the negative one is smaller
        if (o.slt) begin
            if (o.slt_signed && (opa[31] != opb[31])) begin
                res = {31'b0, opa[31]};
            end else begin
                res = {31'b0, opa < opb};
            end
        end
        r.cause = (o.allow_ovf && (o.func inside {ADD, SUB}) && ovf) ? OVERFLOW : NONE;
        r.data  = res;
        if (o.mem_req) begin
            if ((r.cause == NONE) && (((o.size == HALF) && res[0]) ||
                                      ((o.size == WORD) && (res[1:0] != 2'b00)))) begin
                r.cause = MISALIGNED;
            end
            widx = res[7:2];
            word = shadow[widx];
            // big-endian lanes, half lane picked by address bit 1
            hi = (o.size == BYTE) ? 31 - 8 * int'(res[1:0]) : 31 - 16 * int'(res[1]);
            if (o.mem_write) begin
                if (r.cause == NONE) begin
                    case (o.size)
                        BYTE:    word[hi -: 8] = o.b[7:0];
                        HALF:    word[hi -: 16] = o.b[15:0];
                        default: word = o.b;
                    endcase
                    shadow[widx] = word;
                end
            end else begin
                case (o.size)
                    BYTE: r.data = o.load_sign ? {{24{word[hi]}}, word[hi -: 8]} :
                                                 {24'b0, word[hi -: 8]};
                    HALF: r.data = o.load_sign ? {{16{word[hi]}}, word[hi -: 16]} :
                                                 {16'b0, word[hi -: 16]};
                    default: r.data = word;
                endcase
            end
        end
        r.wr_en = o.reg_write && (r.cause == NONE);
        r.rd    = o.rd;
        return r;
    endfunction

    // load or store, address formed as base + 4 through the alu
    function automatic exu_op_t mem_op(input logic wr, input mem_size_t sz, input logic sgn,
                                       input logic [31:0] addr, input logic [31:0] data);
        exu_op_t o;
        o           = '0;
        o.func      = ADD;
        o.alu_imm   = 1'b1;
        o.mem_req   = 1'b1;
        o.mem_write = wr;
        o.size      = sz;
        o.load_sign = sgn;
        o.reg_write = !wr;
        o.rd        = 5'd7;
        o.a         = addr - 32'd4;
        o.imm       = 32'd4;
        o.b         = data;
        return o;
    endfunction

    task automatic show_mismatch(input string sig, input logic [31:0] e, input logic [31:0] a);
        $display("ERR %s expected 0x%h actual 0x%h", sig, e, a);
        errors++;
    endtask

    task automatic check_result(input exu_result_t exp, input exu_result_t act);
        checks++;
        if (act.wr_en !== exp.wr_en)
            show_mismatch("o_wb.wr_en", 32'(exp.wr_en), 32'(act.wr_en));
        if (act.rd !== exp.rd)
            show_mismatch("o_wb.rd", 32'(exp.rd), 32'(act.rd));
        if (act.data !== exp.data)
            show_mismatch("o_wb.data", exp.data, act.data);
        if (act.cause !== exp.cause)
            show_mismatch("o_wb.cause", 32'(exp.cause), 32'(act.cause));
    endtask

    // one op per rising edge, expectation queued at the same time
    task automatic issue(input exu_op_t o);
        @(posedge clk);
        op_valid <= 1'b1;
        op       <= o;
        exp_q.push_back(model_op(o));
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        op_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        tests++;
        $display("test %-10s %s, %0d errors", name,
                 (errors == test_err0) ? "ok" : "FAILED", errors - test_err0);
        test_err0 = errors;
    endtask

    // outputs sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("result strobe at cycle %0d with no operation outstanding", cycles);
                errors++;
            end else begin
                check_result(exp_q.pop_front(), wb);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, %0d results outstanding", cycles, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // every function in register and immediate form, shifts also by imm[10:6]
    task automatic test_alu();
        exu_op_t o;
        for (int f = 0; f <= 9; f++) begin
            o           = '0;
            o.func      = alu_func_t'(f);
            o.reg_write = 1'b1;
            o.rd        = 5'(f + 1);
            o.a         = 32'h8765_4329;
            o.b         = 32'hf0f0_1234;
            // imm[10:6] is 7
            o.imm       = 32'hffff_81c5;
            issue(o);
            o.alu_imm = 1'b1;
            issue(o);
            if (o.func inside {SLL, SRL, SRA}) begin
                o.alu_imm   = 1'b0;
                o.shift_imm = 1'b1;
                issue(o);
            end
        end
        end_test("alu");
    endtask

    task automatic test_slt();
        exu_op_t o;
        o           = '0;
        o.func      = SUB;
        o.slt       = 1'b1;
        o.reg_write = 1'b1;
        o.rd        = 5'd2;
        for (int k = 0; k < 2; k++) begin
            o.a = (k == 0) ? 32'hffff_fff0 : 32'h0000_0005;
            o.b = (k == 0) ? 32'h0000_0005 : 32'hffff_fff0;
            o.slt_signed = 1'b1;
            issue(o);
            o.slt_signed = 1'b0;
            issue(o);
        end
        end_test("slt");
    endtask

    task automatic test_ovf();
        exu_op_t o;
        o           = '0;
        o.func      = ADD;
        o.reg_write = 1'b1;
        o.rd        = 5'd3;
        o.a         = 32'h7fff_ffff;
        o.b         = 32'h0000_0001;
        o.allow_ovf = 1'b1;
        issue(o);
        o.allow_ovf = 1'b0;
        issue(o);
        // most negative minus one
        o.func      = SUB;
        o.a         = 32'h8000_0000;
        o.allow_ovf = 1'b1;
        issue(o);
        end_test("overflow");
    endtask

    task automatic test_mem();
        issue(mem_op(1'b1, WORD, 1'b0, 32'h40, 32'h1122_3344));
        // upper store data bits must not leak into other lanes
        for (int k = 0; k < 4; k++) begin
            issue(mem_op(1'b1, BYTE, 1'b0, 32'h44 + k, 32'hdead_be7e + k));
        end
        issue(mem_op(1'b1, HALF, 1'b0, 32'h48, 32'h0000_8001));
        issue(mem_op(1'b1, HALF, 1'b0, 32'h4a, 32'h1234_7ffe));
        // byte merged into the middle of an existing word
        issue(mem_op(1'b1, BYTE, 1'b0, 32'h42, 32'h0000_00a5));
        for (int w = 0; w < 3; w++) begin
            issue(mem_op(1'b0, WORD, 1'b0, 32'h40 + 4 * w, '0));
        end
        for (int k = 0; k < 8; k++) begin
            issue(mem_op(1'b0, BYTE, 1'b1, 32'h40 + k, '0));
            issue(mem_op(1'b0, BYTE, 1'b0, 32'h40 + k, '0));
        end
        for (int k = 0; k < 2; k++) begin
            issue(mem_op(1'b0, HALF, 1'b1, 32'h48 + 2 * k, '0));
            issue(mem_op(1'b0, HALF, 1'b0, 32'h48 + 2 * k, '0));
        end
        end_test("mem");
    endtask

    task automatic test_misaligned();
        issue(mem_op(1'b1, WORD, 1'b0, 32'h50, 32'hcafe_f00d));
        issue(mem_op(1'b1, HALF, 1'b0, 32'h51, 32'h0000_1234));
        issue(mem_op(1'b1, HALF, 1'b0, 32'h53, 32'h0000_5678));
        issue(mem_op(1'b1, WORD, 1'b0, 32'h52, 32'h9abc_def0));
        issue(mem_op(1'b1, WORD, 1'b0, 32'h51, 32'h0bad_0bad));
        issue(mem_op(1'b0, HALF, 1'b1, 32'h51, '0));
        issue(mem_op(1'b0, WORD, 1'b0, 32'h53, '0));
        // the word must still hold the first store
        issue(mem_op(1'b0, WORD, 1'b0, 32'h50, '0));
        end_test("misalign");
    endtask

    task automatic test_random();
        exu_op_t     o;
        logic [31:0] addr;
        logic [31:0] last_st;
        logic        follow;
        int          kind;
        mem_size_t   sz;
        follow  = 1'b0;
        last_st = '0;
        for (int n = 0; n < 200; n++) begin
            kind = $urandom_range(0, 3);
            sz   = mem_size_t'($urandom_range(0, 2));
            // random upper bits alias onto the 64-word memory
            addr = {24'($urandom), 6'($urandom), 2'b00};
            if (($urandom_range(0, 7) == 0) || (sz == BYTE)) begin
                addr[1:0] = 2'($urandom);
            end else if (sz == HALF) begin
                addr[1] = 1'($urandom);
            end
            if (follow) begin
                // load right behind a store to the same word
                o      = mem_op(1'b0, sz, 1'($urandom), last_st, '0);
                follow = 1'b0;
            end else if (kind < 2) begin
                o            = '0;
                o.func       = alu_func_t'($urandom_range(0, 9));
                o.alu_imm    = 1'($urandom);
                o.shift_imm  = 1'($urandom);
                o.slt        = ($urandom_range(0, 3) == 0);
                o.slt_signed = 1'($urandom);
                o.allow_ovf  = 1'($urandom);
                o.reg_write  = 1'b1;
                o.rd         = 5'($urandom);
                o.a          = $urandom;
                o.b          = $urandom;
                o.imm        = $urandom;
            end else if (kind == 2) begin
                o = mem_op(1'b0, sz, 1'($urandom), addr, '0);
            end else begin
                o       = mem_op(1'b1, sz, 1'b0, addr, $urandom);
                last_st = addr;
                follow  = 1'($urandom);
            end
            issue(o);
        end
        end_test("random");
    endtask

    initial begin
        void'($urandom(40));
        for (int i = 0; i < DMEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        arst_n   = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        test_alu();
        test_slt();
        test_ovf();
        test_mem();
        test_misaligned();
        test_random();
        // bound assertion failures count as errors too
        errors += i_dut.u_asserts.fail_cnt;
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/exu_alu_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage: operand muxing, alu, set-less-than,
// overflow trap and the execute to memory register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module exu_alu_stage (
    input  wire                  clk,
    input  wire                  i_arst_n,
    input  logic                 i_valid,
    input  exu_pkg::exu_op_t     i_op,
    output logic                 o_valid,
    output exu_pkg::exu_mem_op_t o_mem_op
);
    import exu_pkg::*;

    localparam int MSB = DATA_W - 1;

    logic [DATA_W-1:0]  opnd_a;
    logic [DATA_W-1:0]  opnd_b;
    logic [SHAMT_W-1:0] shamt;
    logic [DATA_W-1:0]  sum;
    logic [DATA_W-1:0]  diff;
    logic [DATA_W-1:0]  alu_res;
    logic [DATA_W-1:0]  exe_res;
    logic               add_ovf;
    logic               sub_ovf;
    logic               ovf_trap;
    logic               lt_u;
    logic               lt_s;
    exu_mem_op_t        mem_op_d;

    // operand a is rs, or the zero-extended shift amount from imm[10:6]
    assign opnd_a = i_op.shift_imm ?
                    {{(DATA_W-SHAMT_W){1'b0}}, i_op.imm[SHAMT_LSB +: SHAMT_W]} :
                    i_op.a;
    // operand b is the immediate or rt
    assign opnd_b = i_op.alu_imm ? i_op.imm : i_op.b;

    // shift amount always comes from the low bits of operand a
    assign shamt = opnd_a[SHAMT_W-1:0];

    assign sum  = opnd_a + opnd_b;
    assign diff = opnd_a - opnd_b;

    // two's complement overflow
    // add: same signs in, different sign out
    assign add_ovf = (opnd_a[MSB] == opnd_b[MSB]) && (sum[MSB] != opnd_a[MSB]);
    // sub: different signs in, result sign differs from a
    assign sub_ovf = (opnd_a[MSB] != opnd_b[MSB]) && (diff[MSB] != opnd_a[MSB]);

    // trap only for add/sub, and only when the op asks for it
    assign ovf_trap = i_op.allow_ovf &&
                      (((i_op.func == ADD) && add_ovf) || ((i_op.func == SUB) && sub_ovf));

    // comparators for slt / sltu
    assign lt_u = opnd_a < opnd_b;
    assign lt_s = $signed(opnd_a) < $signed(opnd_b);

    always_comb begin
        case (i_op.func)
            ADD:     alu_res = sum;
            SUB:     alu_res = diff;
            AND:     alu_res = opnd_a & opnd_b;
            OR:      alu_res = opnd_a | opnd_b;
            XOR:     alu_res = opnd_a ^ opnd_b;
            NOR:     alu_res = ~(opnd_a | opnd_b);
            // shifts move operand b
            SLL:     alu_res = opnd_b << shamt;
            SRL:     alu_res = opnd_b >> shamt;
            SRA:     alu_res = $unsigned($signed(opnd_b) >>> shamt);
            // immediate low half into the upper half
            LUI:     alu_res = {i_op.imm[15:0], 16'h0000};
            default: alu_res = sum;
        endcase
    end

    // slt overrides the alu output with a 0/1 word
    assign exe_res = i_op.slt ?
                     {{(DATA_W-1){1'b0}}, (i_op.slt_signed ? lt_s : lt_u)} :
                     alu_res;

    // payload for the memory stage
    always_comb begin
        mem_op_d.result     = exe_res;
        mem_op_d.store_data = i_op.b;
        mem_op_d.mem_req    = i_op.mem_req;
        mem_op_d.mem_write  = i_op.mem_write;
        mem_op_d.size       = i_op.size;
        mem_op_d.load_sign  = i_op.load_sign;
        mem_op_d.reg_write  = i_op.reg_write;
        mem_op_d.rd         = i_op.rd;
        mem_op_d.cause      = ovf_trap ? OVERFLOW : NONE;
    end

    // valid bit, one cycle per accepted op
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // payload captured only with a valid op
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_mem_op <= mem_op_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/exu_dmem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// local word-wide data memory, async read, clocked write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module exu_dmem (
    input  wire                         clk,
    input  wire                         i_arst_n,
    input  exu_pkg::dmem_req_t          i_req,
    output logic [exu_pkg::DATA_W-1:0]  o_rdata
);
    import exu_pkg::*;

    logic [DATA_W-1:0] mem [DMEM_WORDS];

    // the memory starts out all zero after reset
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_req.we) begin
            mem[i_req.addr] <= i_req.wdata;
        end
    end

    // combinational read of the addressed word
    // a store's merge uses this same read in its cycle
    assign o_rdata = mem[i_req.addr];

endmodule

`default_nettype wire

// File: hw/exu_mem_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage: big-endian lanes, store merge, load extract,
// misalignment check and the result register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module exu_mem_stage (
    input  wire                         clk,
    input  wire                         i_arst_n,
    input  logic                        i_valid,
    input  exu_pkg::exu_mem_op_t        i_mem_op,
    output exu_pkg::dmem_req_t          o_dmem_req,
    input  logic [exu_pkg::DATA_W-1:0]  i_dmem_rdata,
    output logic                        o_wb_valid,
    output exu_pkg::exu_result_t        o_wb
);
    import exu_pkg::*;

    logic [1:0]        offset;
    logic [DATA_W-1:0] lane_mask;
    // largest lane shift is 24
    logic [4:0]        lane_shift;
    logic              misaligned;
    exc_cause_t        cause;
    logic              is_load;
    logic [DATA_W-1:0] merged;
    logic [DATA_W-1:0] load_raw;
    logic [DATA_W-1:0] load_ext;
    exu_result_t       wb_d;

    // byte offset within the word
    assign offset = i_mem_op.result[1:0];

    // lane mask and shift, offset 0 is the most significant lane
    always_comb begin
        case (i_mem_op.size)
            BYTE: begin
                lane_mask  = 32'hff00_0000 >> {offset, 3'b000};
                lane_shift = 5'd24 - {offset, 3'b000};
            end
            HALF: begin
                // offset[0] is the misaligned case, lane follows offset[1]
                lane_mask  = offset[1] ? 32'h0000_ffff : 32'hffff_0000;
                lane_shift = offset[1] ? 5'd0 : 5'd16;
            end
            default: begin
                lane_mask  = '1;
                lane_shift = 5'd0;
            end
        endcase
    end

    // half needs bit 0 clear, word needs both low bits clear
    // an op already carrying a cause keeps it
    always_comb begin
        misaligned = 1'b0;
        if (i_mem_op.mem_req && (i_mem_op.cause == NONE)) begin
            case (i_mem_op.size)
                HALF:    misaligned = offset[0];
                WORD:    misaligned = |offset;
                default: misaligned = 1'b0;
            endcase
        end
    end

    assign cause   = misaligned ? MISALIGNED : i_mem_op.cause;
    assign is_load = i_mem_op.mem_req && !i_mem_op.mem_write;

    // read-modify-write of the addressed word
    assign merged = (i_dmem_rdata & ~lane_mask) |
                    ((i_mem_op.store_data << lane_shift) & lane_mask);

    // word address from result[7:2], upper address bits alias
    assign o_dmem_req.addr  = i_mem_op.result[DMEM_AW+1:2];
    assign o_dmem_req.wdata = merged;
    // write only for a live store with no exception
    assign o_dmem_req.we    = i_valid && i_mem_op.mem_req && i_mem_op.mem_write &&
                              (cause == NONE);

    // select the lane and bring it down to bit 0
    assign load_raw = (i_dmem_rdata & lane_mask) >> lane_shift;

    // optional sign extension for byte and half loads
    always_comb begin
        case (i_mem_op.size)
            BYTE: begin
                load_ext = i_mem_op.load_sign ?
                           {{(DATA_W-8){load_raw[7]}}, load_raw[7:0]} : load_raw;
            end
            HALF: begin
                load_ext = i_mem_op.load_sign ?
                           {{(DATA_W-16){load_raw[15]}}, load_raw[15:0]} : load_raw;
            end
            default: begin
                load_ext = load_raw;
            end
        endcase
    end

    // result word, register write killed by any exception
    always_comb begin
        wb_d.wr_en = i_mem_op.reg_write && (cause == NONE);
        wb_d.rd    = i_mem_op.rd;
        wb_d.data  = is_load ? load_ext : i_mem_op.result;
        wb_d.cause = cause;
    end

    // result strobe
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_valid;
        end
    end

    // result payload, held between strobes
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_wb <= wb_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/exu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, enums and stage payload structs for the
// two-stage execute / memory pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package exu_pkg;

    // operand and register index widths
    localparam int DATA_W      = 32;
    localparam int REG_IDX_W   = 5;

    // shift amount sits in imm[10:6]
    localparam int SHAMT_LSB   = 6;
    localparam int SHAMT_W     = 5;

    // local data memory, word addressed
    localparam int DMEM_AW     = 6;
    localparam int DMEM_WORDS  = 64;

    // accept edge to result strobe
    localparam int EXU_LATENCY = 2;

    // alu function select
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        NOR = 4'd5,
        SLL = 4'd6,
        SRL = 4'd7,
        SRA = 4'd8,
        LUI = 4'd9
    } alu_func_t;

    // memory access size
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    // exception cause carried with each result
    typedef enum logic [1:0] {
        NONE       = 2'd0,
        OVERFLOW   = 2'd1,
        MISALIGNED = 2'd2
    } exc_cause_t;

    // one decoded operation as presented to the pipeline
    typedef struct packed {
        alu_func_t             func;
        logic                  alu_imm;
        logic                  shift_imm;
        logic                  slt;
        logic                  slt_signed;
        logic                  allow_ovf;
        logic                  mem_req;
        logic                  mem_write;
        mem_size_t             size;
        logic                  load_sign;
        logic                  reg_write;
        logic [REG_IDX_W-1:0]  rd;
        logic [DATA_W-1:0]     a;
        // b doubles as store data
        logic [DATA_W-1:0]     b;
        logic [DATA_W-1:0]     imm;
    } exu_op_t;

    // execute to memory payload
    typedef struct packed {
        // alu output, or the effective address for loads and stores
        logic [DATA_W-1:0]     result;
        logic [DATA_W-1:0]     store_data;
        logic                  mem_req;
        logic                  mem_write;
        mem_size_t             size;
        logic                  load_sign;
        logic                  reg_write;
        logic [REG_IDX_W-1:0]  rd;
        exc_cause_t            cause;
    } exu_mem_op_t;

    // data memory access
    typedef struct packed {
        logic [DMEM_AW-1:0]    addr;
        logic                  we;
        logic [DATA_W-1:0]     wdata;
    } dmem_req_t;

    // completed operation
    typedef struct packed {
        logic                  wr_en;
        logic [REG_IDX_W-1:0]  rd;
        logic [DATA_W-1:0]     data;
        exc_cause_t            cause;
    } exu_result_t;

endpackage

`default_nettype wire

// File: hw/exu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level: execute stage, memory stage, data memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module exu_top (
    input  wire                   clk,
    input  wire                   i_arst_n,
    input  logic                  i_op_valid,
    input  exu_pkg::exu_op_t      i_op,
    output logic                  o_wb_valid,
    output exu_pkg::exu_result_t  o_wb
);
    import exu_pkg::*;

    // execute to memory
    logic              exe_valid;
    exu_mem_op_t       exe_mem_op;

    // memory stage to data memory
    dmem_req_t         dmem_req;
    logic [DATA_W-1:0] dmem_rdata;

    // first cycle, alu and overflow
    exu_alu_stage u_alu_stage (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_op_valid),
        .i_op     (i_op),
        .o_valid  (exe_valid),
        .o_mem_op (exe_mem_op)
    );

    // second cycle, memory access and result
    exu_mem_stage u_mem_stage (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (exe_valid),
        .i_mem_op     (exe_mem_op),
        .o_dmem_req   (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_wb_valid   (o_wb_valid),
        .o_wb         (o_wb)
    );

    exu_dmem u_dmem (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_req    (dmem_req),
        .o_rdata  (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the exu testbench with Verilator, run it, and check the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log
PASS_LINE="Regression passed"

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert \
    --top-module exu_tb \
    -Mdir "$BUILD_DIR" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can summarize
"./$BUILD_DIR/Vexu_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -qx "$PASS_LINE" "$LOG"; then
    echo "run.sh: PASS"
    exit 0
else
    echo "run.sh: FAIL, see $LOG"
    exit 1
fi

// File: src.f
hw/exu_pkg.sv
hw/exu_alu_stage.sv
hw/exu_mem_stage.sv
hw/exu_dmem.sv
hw/exu_top.sv
bench/exu_asserts.sv
bench/exu_tb.sv
